//--- tb.f
design/ex_pkg.sv
design/ex_ctrl_if.sv
design/ex_control.sv
design/ex_datapath.sv
design/ex_alu.sv
design/ex_stage.sv
testbench/ex_stage_checker.sv
testbench/tb_ex_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_ex_stage -o sim_tb

output=$(./obj_dir/sim_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

//--- testbench/tb_ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int num_bundles = 600;

    typedef struct packed {
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [31:0] redirect_pc;
        mem_size_t   mem_size;
        csr_sel_t    csr_sel;
        logic        is_store;
        logic        imem_en;
        logic        dmem_en;
        logic        bios_en;
        logic        io_en;
        logic        csr_en;
        logic        br_taken;
        logic        br_suc;
        logic        flush;
    } result_t;

    localparam logic [6:0] opcode_list [10] = '{opc_lui, opc_auipc, opc_jal, opc_jalr,
        opc_branch, opc_load, opc_store, opc_ari_itype, opc_ari_rtype, opc_csr};
    localparam logic [2:0] load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    localparam logic [2:0] branch_f3 [6] = '{fnc_beq, fnc_bne, fnc_blt, fnc_bge,
        fnc_bltu, fnc_bgeu};
    // Last entry is an unmapped region
    localparam logic [3:0] region_list [6] = '{addr_dmem, addr_imem, addr_mirror,
        addr_bios, addr_io, 4'hf};

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        target_taken;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] alu_result;
    logic [31:0] store_data;
    mem_size_t   mem_size;
    logic        is_store;
    logic        imem_en;
    logic        dmem_en;
    logic        bios_en;
    logic        io_en;
    logic        csr_en;
    csr_sel_t    csr_sel;
    logic        br_taken;
    logic        br_suc;
    logic        flush;
    logic [31:0] redirect_pc;

    logic [31:0] stim_lfsr;
    logic [31:0] ready_lfsr;
    logic [31:0] b_inst;
    logic [31:0] b_pc;
    logic [31:0] b_rs1;
    logic [31:0] b_rs2;
    logic        b_taken;
    result_t     expected [$];
    int          received = 0;

    ex_stage uut (.*);

    bind ex_stage ex_stage_checker u_checker (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
        .out_valid(out_valid), .out_ready(out_ready), .alu_result(alu_result),
        .store_data(store_data), .redirect_pc(redirect_pc), .mem_size(mem_size),
        .csr_sel(csr_sel),
        .flags({is_store, imem_en, dmem_en, bios_en, io_en, csr_en, br_taken, br_suc, flush}),
        .flush(flush), .br_suc(br_suc)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] rv32_alu(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] x, input logic [31:0] y);
        case (f3)
            fnc_add_sub: return alt ? x - y : x + y;
            fnc_sll:     return x << y[4:0];
            fnc_slt:     return {31'b0, $signed(x) < $signed(y)};
            fnc_sltu:    return {31'b0, x < y};
            fnc_xor:     return x ^ y;
            fnc_srl_sra: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            fnc_or:      return x | y;
            default:     return x & y;
        endcase
    endfunction

    function automatic mem_size_t access_size(input logic [2:0] f3);
        case (f3[1:0])
            2'd0:    return mem_byte;
            2'd1:    return mem_half;
            2'd2:    return mem_word;
            default: return mem_none;
        endcase
    endfunction

    function automatic result_t ref_ex(input logic [31:0] i, input logic [31:0] p,
                                       input logic [31:0] a, input logic [31:0] b,
                                       input logic tt);
        result_t     r;
        logic [2:0]  f3;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [3:0]  region;
        logic        taken;
        f3 = i[14:12];
        imm_i = {{20{i[31]}}, i[31:20]};
        imm_s = {{20{i[31]}}, i[31:25], i[11:7]};
        imm_b = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        imm_u = {i[31:12], 12'b0};
        imm_j = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        r = '0;
        r.mem_size = mem_none;
        r.csr_sel = csr_rd1;
        r.store_data = b;
        r.redirect_pc = p + 32'd4;
        r.alu_result = a + imm_i;
        taken = 1'b0;
        case (i[6:0])
            opc_ari_rtype: r.alu_result = rv32_alu(f3, i[30], a, b);
            opc_ari_itype: r.alu_result = rv32_alu(f3, i[30] && f3 == fnc_srl_sra, a, imm_i);
            opc_lui:       r.alu_result = imm_u;
            opc_auipc:     r.alu_result = p + imm_u;
            opc_jal: begin
                r.alu_result = p + imm_j;
                r.flush = 1'b1;
                r.redirect_pc = r.alu_result;
            end
            opc_jalr: begin
                r.flush = 1'b1;
                r.redirect_pc = {r.alu_result[31:1], 1'b0};
            end
            opc_branch: begin
                case (f3)
                    fnc_beq:  taken = a == b;
                    fnc_bne:  taken = a != b;
                    fnc_blt:  taken = $signed(a) < $signed(b);
                    fnc_bge:  taken = $signed(a) >= $signed(b);
                    fnc_bltu: taken = a < b;
                    fnc_bgeu: taken = a >= b;
                    default:  taken = 1'b0;
                endcase
                r.alu_result = p + imm_b;
                r.br_taken = taken;
                r.br_suc = taken == tt;
                r.flush = taken != tt;
                // Predicted-taken branches already fetched the target
                if (!tt) begin
                    r.redirect_pc = r.alu_result;
                end
            end
            opc_load: begin
                region = r.alu_result[31:28];
                r.mem_size = access_size(f3);
                r.io_en = region == addr_io;
                r.bios_en = region == addr_bios;
                r.dmem_en = region == addr_dmem || region == addr_mirror;
            end
            opc_store: begin
                r.alu_result = a + imm_s;
                region = r.alu_result[31:28];
                r.mem_size = access_size(f3);
                r.is_store = 1'b1;
                r.io_en = region == addr_io;
                r.dmem_en = region == addr_dmem || region == addr_mirror;
                r.imem_en = (region == addr_imem || region == addr_mirror) && p[30];
            end
            opc_csr: begin
                r.csr_en = 1'b1;
                if (f3 == fnc_csrrwi) begin
                    r.csr_sel = csr_imm;
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic make_bundle();
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] w;
        opc = opcode_list[4'(rand_bits(4) % 32'd10)];
        w = rand_bits(32);
        f3 = w[14:12];
        case (opc)
            opc_ari_rtype: begin
                w[31:25] = {1'b0, w[30] && (f3 == fnc_add_sub || f3 == fnc_srl_sra), 5'b0};
            end
            opc_ari_itype: begin
                if (f3 == fnc_sll || f3 == fnc_srl_sra) begin
                    w[31:25] = {1'b0, w[30] && f3 == fnc_srl_sra, 5'b0};
                end
            end
            opc_load:   f3 = load_f3[3'(rand_bits(3) % 32'd5)];
            opc_store:  f3 = 3'(rand_bits(2) % 32'd3);
            opc_branch: f3 = branch_f3[3'(rand_bits(3) % 32'd6)];
            opc_csr:    f3 = (rand_bits(1) != 32'd0) ? fnc_csrrwi : fnc_csrrw;
            default: ;
        endcase
        w[14:12] = f3;
        w[6:0] = opc;
        b_inst = w;
        b_pc = rand_bits(30) << 2;
        b_rs1 = rand_bits(32);
        if (opc == opc_load || opc == opc_store) begin
            b_rs1[31:28] = region_list[3'(rand_bits(3) % 32'd6)];
        end
        // Equal operands often enough to exercise BEQ and BGE
        if (opc == opc_branch && rand_bits(1) != 32'd0) begin
            b_rs2 = b_rs1;
        end else begin
            b_rs2 = rand_bits(32);
        end
        b_taken = rand_bits(1) != 32'd0;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_size(input string name, input mem_size_t got, input mem_size_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_csr_sel(input string name, input csr_sel_t got, input csr_sel_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        logic bit_a;
        ready_lfsr = 32'h865f_ea23;
        out_ready <= 1'b0;
        forever begin
            @(posedge clk);
            ready_lfsr = lfsr_step(ready_lfsr);
            bit_a = ready_lfsr[0];
            ready_lfsr = lfsr_step(ready_lfsr);
            out_ready <= bit_a | ready_lfsr[0];
        end
    end

    // Output transfers are checked before new acceptances are queued
    initial begin
        result_t exp_r;
        forever begin
            @(posedge clk);
            if (!reset && out_valid && out_ready) begin
                if (expected.size() == 0) begin
                    abort_run("output appeared without a matching input");
                end
                exp_r = expected.pop_front();
                check_word("alu_result", alu_result, exp_r.alu_result);
                check_word("store_data", store_data, exp_r.store_data);
                check_word("redirect_pc", redirect_pc, exp_r.redirect_pc);
                check_size("mem_size", mem_size, exp_r.mem_size);
                check_csr_sel("csr_sel", csr_sel, exp_r.csr_sel);
                check_bit("is_store", is_store, exp_r.is_store);
                check_bit("imem_en", imem_en, exp_r.imem_en);
                check_bit("dmem_en", dmem_en, exp_r.dmem_en);
                check_bit("bios_en", bios_en, exp_r.bios_en);
                check_bit("io_en", io_en, exp_r.io_en);
                check_bit("csr_en", csr_en, exp_r.csr_en);
                check_bit("br_taken", br_taken, exp_r.br_taken);
                check_bit("br_suc", br_suc, exp_r.br_suc);
                check_bit("flush", flush, exp_r.flush);
                received++;
            end
            if (!reset && in_valid && in_ready) begin
                expected.push_back(ref_ex(inst, pc, rs1_data, rs2_data, target_taken));
            end
        end
    end

    initial begin
        repeat (num_bundles * 4 + 100) @(posedge clk);
        abort_run("timeout waiting for outputs");
    end

    initial begin
        stim_lfsr = 32'h865f_ea23;
        reset <= 1'b1;
        in_valid <= 1'b0;
        inst <= '0;
        pc <= '0;
        rs1_data <= '0;
        rs2_data <= '0;
        target_taken <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        // No output may appear while idle after reset
        repeat (4) @(posedge clk);
        for (int n = 0; n < num_bundles; n++) begin
            while (rand_bits(2) == 32'd0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            make_bundle();
            in_valid <= 1'b1;
            inst <= b_inst;
            pc <= b_pc;
            rs1_data <= b_rs1;
            rs2_data <= b_rs2;
            target_taken <= b_taken;
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
        wait (received == num_bundles);
        repeat (4) @(posedge clk);
        if (received == num_bundles && expected.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run("output count does not match the accepted inputs");
        end
    end

endmodule

`default_nettype wire

//--- testbench/ex_stage_checker.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage_checker
    import ex_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        in_valid,
    input logic        in_ready,
    input logic        out_valid,
    input logic        out_ready,
    input logic [31:0] alu_result,
    input logic [31:0] store_data,
    input logic [31:0] redirect_pc,
    input mem_size_t   mem_size,
    input csr_sel_t    csr_sel,
    input logic [8:0]  flags,
    input logic        flush,
    input logic        br_suc
);

    logic [107:0] held;

    assign held = {alu_result, store_data, redirect_pc, mem_size, csr_sel, flags};

    reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high after reset");

    // Stalled output keeps every field
    hold_under_stall: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(held))
        else $error("outputs changed while stalled");

    // Accepted bundle is presented on the next cycle
    accept_fills_output: assert property (@(posedge clk) disable iff (reset)
        in_valid && in_ready |=> out_valid)
        else $error("accepted input did not reach the output register");

    no_flush_on_success: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !(flush && br_suc))
        else $error("flush and br_suc both high");

endmodule

`default_nettype wire

//--- design/ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic        target_taken,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] alu_result,
    output logic [31:0] store_data,
    output mem_size_t   mem_size,
    output logic        is_store,
    output logic        imem_en,
    output logic        dmem_en,
    output logic        bios_en,
    output logic        io_en,
    output logic        csr_en,
    output csr_sel_t    csr_sel,
    output logic        br_taken,
    output logic        br_suc,
    output logic        flush,
    output logic [31:0] redirect_pc
);

    ex_ctrl_if ctrl ();

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic [31:0] redirect_d;
    mem_size_t   size_d;
    csr_sel_t    csr_sel_d;
    logic        is_store_d;
    logic        imem_en_d;
    logic        dmem_en_d;
    logic        bios_en_d;
    logic        io_en_d;
    logic        csr_en_d;
    logic        br_taken_d;
    logic        br_suc_d;
    logic        flush_d;
    logic        accept;

    ex_control u_control (
        .inst(inst), .addr(alu_out), .pc_bios(pc[30]), .target_taken(target_taken),
        .ctrl(ctrl.control), .size(size_d), .is_store(is_store_d),
        .imem_en(imem_en_d), .dmem_en(dmem_en_d), .bios_en(bios_en_d), .io_en(io_en_d),
        .csr_en(csr_en_d), .csr_sel(csr_sel_d), .br_inst(),
        .br_taken(br_taken_d), .br_suc(br_suc_d), .flush(flush_d)
    );

    ex_datapath u_datapath (
        .inst(inst), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ctrl(ctrl.datapath), .op_a(op_a), .op_b(op_b),
        .alu_result_in(alu_out), .redirect_pc(redirect_d)
    );

    ex_alu u_alu (.ctrl(ctrl.alu), .a(op_a), .b(op_b), .result(alu_out));

    // Ready while the output slot is empty or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_result <= alu_out;
            store_data <= rs2_data;
            mem_size <= size_d;
            is_store <= is_store_d;
            imem_en <= imem_en_d;
            dmem_en <= dmem_en_d;
            bios_en <= bios_en_d;
            io_en <= io_en_d;
            csr_en <= csr_en_d;
            csr_sel <= csr_sel_d;
            br_taken <= br_taken_d;
            br_suc <= br_suc_d;
            flush <= flush_d;
            redirect_pc <= redirect_d;
        end
    end

endmodule

`default_nettype wire

//--- design/ex_alu.sv
`timescale 1ns/10ps
`default_nettype none

module ex_alu
    import ex_pkg::*;
(
    ex_ctrl_if.alu      ctrl,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (ctrl.alu_sel)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);
            alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'b0, a < b};
            // LUI passes the upper immediate straight through
            alu_bsel: result = b;
            default:  result = a + b;
        endcase
    end

endmodule

`default_nettype wire

//--- design/ex_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module ex_datapath
    import ex_pkg::*;
(
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    ex_ctrl_if.datapath ctrl,
    output logic [31:0] op_a,
    output logic [31:0] op_b,
    input  logic [31:0] alu_result_in,
    output logic [31:0] redirect_pc
);

    logic [31:0] imm;
    logic [31:0] pc_plus4;
    logic [31:0] jump_target;

    // Immediate format follows the opcode
    always_comb begin
        case (inst[6:0])
            opc_lui, opc_auipc: begin
                imm = {inst[31:12], 12'b0};
            end
            opc_jal: begin
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            opc_branch: begin
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            opc_store: begin
                imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            end
            default: begin
                imm = {{21{inst[31]}}, inst[30:20]};
            end
        endcase
    end

    assign op_a = (ctrl.a_sel == a_pc) ? pc : rs1_data;
    assign op_b = (ctrl.b_sel == b_imm) ? imm : rs2_data;

    // Branch compare works on the register values, not the ALU operands
    assign ctrl.breq = rs1_data == rs2_data;
    assign ctrl.brlt = ctrl.brun ? (rs1_data < rs2_data)
                                 : ($signed(rs1_data) < $signed(rs2_data));

    assign pc_plus4 = pc + 32'd4;
    assign jump_target = ctrl.is_jalr ? {alu_result_in[31:1], 1'b0} : alu_result_in;
    assign redirect_pc = (ctrl.redirect_sel == redir_alu) ? jump_target : pc_plus4;

endmodule

`default_nettype wire

//--- design/ex_control.sv
`timescale 1ns/10ps
`default_nettype none

module ex_control
    import ex_pkg::*;
(
    input  logic [31:0] inst,
    input  logic [31:0] addr,
    input  logic        pc_bios,
    input  logic        target_taken,
    ex_ctrl_if.control  ctrl,
    output mem_size_t   size,
    output logic        is_store,
    output logic        imem_en,
    output logic        dmem_en,
    output logic        bios_en,
    output logic        io_en,
    output logic        csr_en,
    output csr_sel_t    csr_sel,
    output logic        br_inst,
    output logic        br_taken,
    output logic        br_suc,
    output logic        flush
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_load;
    logic       is_jal;

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            fnc_add_sub: return alt ? alu_sub : alu_add;
            fnc_sll:     return alu_sll;
            fnc_slt:     return alu_slt;
            fnc_sltu:    return alu_sltu;
            fnc_xor:     return alu_xor;
            fnc_srl_sra: return alt ? alu_sra : alu_srl;
            fnc_or:      return alu_or;
            default:     return alu_and;
        endcase
    endfunction

    // Unsigned loads share the width bits with the signed forms
    function automatic mem_size_t size_of(input logic [1:0] width);
        case ({1'b0, width})
            fnc_sb:  return mem_byte;
            fnc_sh:  return mem_half;
            fnc_sw:  return mem_word;
            default: return mem_none;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign is_load = opcode == opc_load;
    assign is_store = opcode == opc_store;
    assign is_jal = opcode == opc_jal;
    assign br_inst = opcode == opc_branch;
    assign csr_en = opcode == opc_csr;
    assign ctrl.is_jalr = opcode == opc_jalr;

    always_comb begin
        ctrl.alu_sel = alu_add;
        ctrl.a_sel = a_reg;
        ctrl.b_sel = b_imm;
        ctrl.brun = 1'b0;
        ctrl.redirect_sel = redir_pc4;
        size = mem_none;
        csr_sel = csr_rd1;
        case (opcode)
            opc_ari_rtype: begin
                ctrl.b_sel = b_reg;
                ctrl.alu_sel = arith_op(funct3, inst[30]);
            end
            // Bit 30 of an immediate only selects SRAI
            opc_ari_itype: ctrl.alu_sel = arith_op(funct3, inst[30] && funct3 == fnc_srl_sra);
            opc_load, opc_store: size = size_of(funct3[1:0]);
            opc_branch: begin
                ctrl.a_sel = a_pc;
                ctrl.brun = funct3 == fnc_bltu || funct3 == fnc_bgeu;
                ctrl.redirect_sel = target_taken ? redir_pc4 : redir_alu;
            end
            opc_jal: begin
                ctrl.a_sel = a_pc;
                ctrl.redirect_sel = redir_alu;
            end
            opc_jalr: ctrl.redirect_sel = redir_alu;
            opc_lui: ctrl.alu_sel = alu_bsel;
            opc_auipc: ctrl.a_sel = a_pc;
            opc_csr: begin
                case (funct3)
                    fnc_csrrw:  csr_sel = csr_rd1;
                    fnc_csrrwi: csr_sel = csr_imm;
                    default:    csr_sel = csr_rd1;
                endcase
            end
            default: ;
        endcase
    end

    // Region enables from the computed address
    always_comb begin
        imem_en = 1'b0;
        dmem_en = 1'b0;
        bios_en = 1'b0;
        io_en = 1'b0;
        if (is_load) begin
            case (addr[31:28])
                addr_io:                io_en = 1'b1;
                addr_bios:              bios_en = 1'b1;
                addr_dmem, addr_mirror: dmem_en = 1'b1;
                default: ;
            endcase
        end else if (is_store) begin
            case (addr[31:28])
                addr_io:   io_en = 1'b1;
                addr_dmem: dmem_en = 1'b1;
                // IMEM is writable only from code running in BIOS
                addr_imem: imem_en = pc_bios;
                addr_mirror: begin
                    imem_en = pc_bios;
                    dmem_en = 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        br_taken = 1'b0;
        if (br_inst) begin
            case (funct3)
                fnc_beq:            br_taken = ctrl.breq;
                fnc_bne:            br_taken = !ctrl.breq;
                fnc_blt, fnc_bltu:  br_taken = ctrl.brlt;
                fnc_bge, fnc_bgeu:  br_taken = !ctrl.brlt;
                default: ;
            endcase
        end
    end

    assign br_suc = br_inst && br_taken == target_taken;
    assign flush = ctrl.is_jalr || is_jal || (br_inst && br_taken != target_taken);

endmodule

`default_nettype wire

//--- design/ex_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ex_ctrl_if
    import ex_pkg::*;
();

    alu_op_t    alu_sel;
    a_sel_t     a_sel;
    b_sel_t     b_sel;
    logic       brun;
    redir_sel_t redirect_sel;
    logic       is_jalr;
    logic       breq;
    logic       brlt;

    modport control (
        output alu_sel, a_sel, b_sel, brun, redirect_sel, is_jalr,
        input  breq, brlt
    );

    modport datapath (
        input  a_sel, b_sel, brun, redirect_sel, is_jalr,
        output breq, brlt
    );

    modport alu (input alu_sel);

endinterface

`default_nettype wire

//--- design/ex_pkg.sv
`default_nettype none

package ex_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll,
        alu_srl, alu_sra, alu_slt, alu_sltu, alu_bsel
    } alu_op_t;

    typedef enum logic [1:0] {mem_byte, mem_half, mem_word, mem_none} mem_size_t;
    typedef enum logic {a_reg, a_pc} a_sel_t;
    typedef enum logic {b_reg, b_imm} b_sel_t;
    // Branches predicted taken fall back to the sequential PC
    typedef enum logic {redir_alu, redir_pc4} redir_sel_t;
    typedef enum logic {csr_rd1, csr_imm} csr_sel_t;

    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_ari_itype = 7'b0010011;
    localparam logic [6:0] opc_ari_rtype = 7'b0110011;
    localparam logic [6:0] opc_csr       = 7'b1110011;

    localparam logic [2:0] fnc_add_sub = 3'b000;
    localparam logic [2:0] fnc_sll     = 3'b001;
    localparam logic [2:0] fnc_slt     = 3'b010;
    localparam logic [2:0] fnc_sltu    = 3'b011;
    localparam logic [2:0] fnc_xor     = 3'b100;
    localparam logic [2:0] fnc_srl_sra = 3'b101;
    localparam logic [2:0] fnc_or      = 3'b110;
    localparam logic [2:0] fnc_and     = 3'b111;

    localparam logic [2:0] fnc_sb      = 3'b000;
    localparam logic [2:0] fnc_sh      = 3'b001;
    localparam logic [2:0] fnc_sw      = 3'b010;

    localparam logic [2:0] fnc_beq     = 3'b000;
    localparam logic [2:0] fnc_bne     = 3'b001;
    localparam logic [2:0] fnc_blt     = 3'b100;
    localparam logic [2:0] fnc_bge     = 3'b101;
    localparam logic [2:0] fnc_bltu    = 3'b110;
    localparam logic [2:0] fnc_bgeu    = 3'b111;

    localparam logic [2:0] fnc_csrrw   = 3'b001;
    localparam logic [2:0] fnc_csrrwi  = 3'b101;

    // Memory map regions on address bits 31 to 28
    localparam logic [3:0] addr_dmem   = 4'd1;
    localparam logic [3:0] addr_imem   = 4'd2;
    localparam logic [3:0] addr_mirror = 4'd3;
    localparam logic [3:0] addr_bios   = 4'd4;
    localparam logic [3:0] addr_io     = 4'd8;

endpackage

`default_nettype wire
